//--- dv/plic_regs_tb.sv
`timescale 1ns/10ps

module plic_regs_tb;
  import plic_pkg::*;

  localparam int SOURCES = 6;
  localparam int TARGETS = 2;
  // Cycles to wait for pready
  localparam int TIMEOUT = 20;
  // Three priority bits for each of the six built sources
  localparam logic [31:0] PRIO_MASK = 32'h0077_7777;
  // Sources 6, targets 2, levels 8, threshold present
  localparam logic [31:0] CONFIG_EXP = 32'h0108_0206;

  logic                            clk;
  logic                            rst_n;
  apb_req_t                        apb_req;
  apb_rsp_t                        apb_rsp;
  logic [TARGETS-1:0][ID_W-1:0]    id;
  prio_word_u                      prio;
  logic [TARGETS-1:0][SOURCES-1:0] ie;
  logic [TARGETS-1:0][PRIO_W-1:0]  th;
  logic [TARGETS-1:0]              claim;
  logic [TARGETS-1:0]              complete;

  // Strobes expected in the current cycle
  logic [TARGETS-1:0]              exp_claim;
  logic [TARGETS-1:0]              exp_complete;

  // Register model
  logic [31:0]                     m_prio;
  logic [TARGETS-1:0][SOURCES-1:0] m_ie;
  logic [TARGETS-1:0][PRIO_W-1:0]  m_th;

  integer                          seed;
  int                              errors;
  int                              checks;
  int                              test_err;

  plic_regs #(
    .SOURCES (SOURCES),
    .TARGETS (TARGETS)
  ) i_plic_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .id       (id),
    .prio     (prio),
    .ie       (ie),
    .th       (th),
    .claim    (claim),
    .complete (complete)
  );

  initial
    clk = 1'b0;

  always #10 clk = ~clk;

  ////////////////////
  // Protocol checks
  ////////////////////

  // Claim only in the access phase of an ID read
  claim_check: assert property (@(posedge clk) disable iff (!rst_n) claim == exp_claim)
  else
  begin
    $display("** Error at %0t: claim is %b, expected %b", $time, $sampled(claim),
             $sampled(exp_claim));
    errors++;
  end

  // Complete only in the access phase of an ID write
  complete_check: assert property (@(posedge clk) disable iff (!rst_n)
                                   complete == exp_complete)
  else
  begin
    $display("** Error at %0t: complete is %b, expected %b", $time, $sampled(complete),
             $sampled(exp_complete));
    errors++;
  end

  // No response outside an access phase
  idle_check: assert property (@(posedge clk) disable iff (!rst_n)
    !(apb_req.psel && apb_req.penable) |-> !(apb_rsp.pready || apb_rsp.pslverr))
  else
  begin
    $display("** Error at %0t: pready or pslverr high outside access phase", $time);
    errors++;
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Byte lane merge by expanded strobe mask
  function automatic logic [31:0] merge_lanes(
    input logic [31:0] old_w,
    input logic [31:0] new_w,
    input logic [3:0]  strb
  );
    logic [31:0] lane_mask;
    lane_mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~lane_mask) | (new_w & lane_mask);
  endfunction

  task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    value_check: assert (got === exp)
    else
    begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // One APB transfer in setup and access phases with data sampled at the falling edge
  task automatic apb_xfer(
    input  logic               write,
    input  logic [ADDR_W-1:0]  addr,
    input  logic [31:0]        wdata,
    input  logic [3:0]         strb,
    input  logic [TARGETS-1:0] cl,
    input  logic [TARGETS-1:0] co,
    output logic [31:0]        rdata,
    output logic               err
  );
    int cnt;
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= write;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    apb_req.pstrb   <= strb;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    exp_claim       <= cl;
    exp_complete    <= co;
    cnt = 0;
    @(negedge clk);
    while (!apb_rsp.pready && cnt < TIMEOUT)
    begin
      @(negedge clk);
      cnt++;
    end
    if (!apb_rsp.pready)
    begin
      $display("Timeout: no pready from the DUT within %0d cycles", TIMEOUT);
      $display("Testbench failed");
      $finish;
    end
    else
    begin
      // Zero wait states, pready in the first access cycle
      check_val("pready wait cycles", 32'(cnt), 32'h0);
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      // Transfer ends on this edge
      @(posedge clk);
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
      exp_claim       <= '0;
      exp_complete    <= '0;
    end
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb, output logic err);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, wdata, strb, '0, '0, unused, err);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [31:0] rdata,
                          output logic err);
    apb_xfer(1'b0, addr, 32'h0, 4'h0, '0, '0, rdata, err);
  endtask

  // Reads every writable register and compares bus and outputs with the model
  task automatic full_readback();
    logic [31:0] rd;
    logic        err;
    logic        any_err;
    apb_read(ADDR_PRIORITY, rd, any_err);
    check_val("priority readback", rd, m_prio);
    check_val("priority output", prio.raw, m_prio);
    for (int t = 0; t < TARGETS; t++)
    begin
      apb_read(ADDR_ENABLE_BASE + 24'(4 * t), rd, err);
      any_err |= err;
      check_val("enable readback", rd, 32'(m_ie[t]));
      check_val("enable output", 32'(ie[t]), 32'(m_ie[t]));
      apb_read(ADDR_THRESHOLD_BASE + 24'(t * 4096), rd, err);
      any_err |= err;
      check_val("threshold readback", rd, 32'(m_th[t]));
      check_val("threshold output", 32'(th[t]), 32'(m_th[t]));
    end
    check_val("readback pslverr", 32'(any_err), 32'h0);
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d %s: done, %0d errors", num, name, errors - test_err);
    test_err = errors;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  initial
  begin
    logic [31:0]       rd;
    logic              err;
    logic [31:0]       data;
    logic [3:0]        strb;
    logic [7:0]        id_val;
    logic [ADDR_W-1:0] id_addr;
    logic [ADDR_W-1:0] bad_addr [7];
    int                t;
    seed     = 32'h9175;
    errors   = 0;
    checks   = 0;
    test_err = 0;
    m_prio   = '0;
    m_ie     = '0;
    m_th     = '0;
    rst_n        <= 1'b0;
    apb_req      <= '0;
    id           <= '0;
    exp_claim    <= '0;
    exp_complete <= '0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Reset values and config word
    full_readback();
    apb_read(ADDR_CONFIG, rd, err);
    check_val("config word", rd, CONFIG_EXP);
    check_val("config pslverr", 32'(err), 32'h0);
    report_test(1, "reset values");

    // Priority byte merge with nibble masking
    for (int i = 0; i < 8; i++)
    begin
      data = $random(seed);
      strb = $random(seed);
      apb_write(ADDR_PRIORITY, data, strb, err);
      check_val("priority write pslverr", 32'(err), 32'h0);
      m_prio = merge_lanes(m_prio, data, strb) & PRIO_MASK;
      apb_read(ADDR_PRIORITY, rd, err);
      check_val("priority readback", rd, m_prio);
      check_val("priority output", prio.raw, m_prio);
    end
    report_test(2, "priority writes");

    // Enable words on alternating targets with upper source bits dropped
    for (int i = 0; i < 8; i++)
    begin
      t    = i % TARGETS;
      data = $random(seed);
      strb = $random(seed);
      apb_write(ADDR_ENABLE_BASE + 24'(4 * t), data, strb, err);
      check_val("enable write pslverr", 32'(err), 32'h0);
      m_ie[t] = SOURCES'(merge_lanes(32'(m_ie[t]), data, strb));
      full_readback();
    end
    report_test(3, "enable writes");

    // Threshold takes byte 0 only under strobe 0
    for (int i = 0; i < 8; i++)
    begin
      t    = i % TARGETS;
      data = $random(seed);
      strb = $random(seed);
      apb_write(ADDR_THRESHOLD_BASE + 24'(t * 4096), data, strb, err);
      check_val("threshold write pslverr", 32'(err), 32'h0);
      if (strb[0])
        m_th[t] = data[PRIO_W-1:0];
      full_readback();
    end
    report_test(4, "threshold writes");

    // Claim on ID read, complete on ID write
    for (int k = 0; k < TARGETS; k++)
    begin
      id_val = $random(seed);
      @(posedge clk);
      id <= id_val;
      id_addr = ADDR_THRESHOLD_BASE + 24'(k * 4096) + ADDR_ID_OFFSET;
      apb_xfer(1'b0, id_addr, 32'h0, 4'h0, TARGETS'(1 << k), '0, rd, err);
      check_val("claim ID", rd, 32'(id_val[k*ID_W +: ID_W]));
      check_val("claim pslverr", 32'(err), 32'h0);
      data = $random(seed);
      apb_xfer(1'b1, id_addr, data, 4'hf, '0, TARGETS'(1 << k), rd, err);
      check_val("complete pslverr", 32'(err), 32'h0);
    end
    full_readback();
    report_test(5, "claim and complete");

    // Unmapped, misaligned and target 2 addresses
    bad_addr[0] = 24'h000008;
    bad_addr[1] = 24'h001000;
    bad_addr[2] = 24'h002008;
    bad_addr[3] = 24'h202000;
    bad_addr[4] = 24'h202004;
    bad_addr[5] = 24'h200008;
    bad_addr[6] = 24'h002001;
    for (int i = 0; i < 7; i++)
    begin
      data = $random(seed);
      apb_write(bad_addr[i], data, 4'hf, err);
      check_val("pslverr on bad write", 32'(err), 32'h1);
      apb_read(bad_addr[i], rd, err);
      check_val("pslverr on bad read", 32'(err), 32'h1);
    end
    // Config is read-only
    apb_write(ADDR_CONFIG, 32'hffff_ffff, 4'hf, err);
    check_val("pslverr on config write", 32'(err), 32'h1);
    apb_read(ADDR_CONFIG, rd, err);
    check_val("config after write", rd, CONFIG_EXP);
    full_readback();
    report_test(6, "error responses");

    $display("Tests run: 6, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

//--- plic_regs.f
verilog/plic_pkg.sv
verilog/plic_apb_ctrl.sv
verilog/plic_priority_regs.sv
verilog/plic_enable_regs.sv
verilog/plic_target_regs.sv
verilog/plic_regs.sv
dv/plic_regs_tb.sv

//--- verilog/plic_apb_ctrl.sv
`timescale 1ns/10ps

module plic_apb_ctrl #(
  parameter int SOURCES = 8,
  parameter int TARGETS = 2
) (
  input  plic_pkg::apb_req_t                       apb_req,
  output plic_pkg::apb_rsp_t                       apb_rsp,
  output plic_pkg::reg_wr_t                        wr,
  output plic_pkg::tidx_t                          rd_target,
  output logic [TARGETS-1:0]                       claim,
  output logic [TARGETS-1:0]                       complete,
  input  plic_pkg::prio_word_u                     prio_rdata,
  input  logic [TARGETS-1:0][SOURCES-1:0]          ie_rdata,
  input  logic [TARGETS-1:0][plic_pkg::PRIO_W-1:0] th_rdata,
  input  logic [TARGETS-1:0][plic_pkg::DATA_W-1:0] id_rdata
);
  import plic_pkg::*;

  // Target index position in the enable and threshold windows
  localparam int EN_LSB = 2;
  localparam int TH_LSB = 12;

  logic [ADDR_W-1:0] addr;
  logic              access;
  tidx_t             en_idx;
  tidx_t             th_idx;
  tidx_t             idx;
  logic              en_win;
  logic              th_win;
  logic [TH_LSB-1:0] th_off;
  logic              hit_config;
  logic              hit_prio;
  logic              hit_en;
  logic              hit_th;
  logic              hit_id;
  logic              mapped;
  logic              err;
  config_word_t      cfg;
  logic [DATA_W-1:0] rdata;

  ////////////////////
  // Address decode
  ////////////////////

  assign addr   = apb_req.paddr;
  // Access phase, every one completes in a single cycle
  assign access = apb_req.psel & apb_req.penable;

  assign en_idx = addr[EN_LSB +: TIDX_W];
  assign th_idx = addr[TH_LSB +: TIDX_W];
  assign th_off = addr[TH_LSB-1:0];

  // Enable window, word aligned
  assign en_win = (addr[ADDR_W-1:EN_LSB+TIDX_W] == ADDR_ENABLE_BASE[ADDR_W-1:EN_LSB+TIDX_W]) &&
                  (addr[EN_LSB-1:0] == '0);
  // Per-target page holding threshold and claim/complete
  assign th_win = addr[ADDR_W-1:TH_LSB+TIDX_W] == ADDR_THRESHOLD_BASE[ADDR_W-1:TH_LSB+TIDX_W];

  assign hit_config = addr == ADDR_CONFIG;
  assign hit_prio   = addr == ADDR_PRIORITY;
  // Index must name a built target
  assign hit_en     = en_win && (int'(en_idx) < TARGETS);
  assign hit_th     = th_win && (th_off == '0) && (int'(th_idx) < TARGETS);
  assign hit_id     = th_win && (th_off == ADDR_ID_OFFSET[TH_LSB-1:0]) &&
                      (int'(th_idx) < TARGETS);

  assign mapped = hit_config | hit_prio | hit_en | hit_th | hit_id;
  // Config is read-only
  assign err    = ~mapped | (apb_req.pwrite & hit_config);

  assign idx       = hit_en ? en_idx : th_idx;
  assign rd_target = idx;

  ////////////////////
  // Write request
  ////////////////////

  assign wr.sel.prio   = hit_prio;
  assign wr.sel.enable = hit_en;
  assign wr.sel.target = hit_th;
  assign wr.tidx       = idx;
  // ID writes store nothing, they only raise complete
  assign wr.we         = access & apb_req.pwrite & (hit_prio | hit_en | hit_th);
  assign wr.wdata      = apb_req.pwdata;
  assign wr.strb       = apb_req.pstrb;

  // Claim and complete strobes, one-hot on the addressed target
  always_comb
  begin
    for (int t = 0; t < TARGETS; t++)
    begin
      claim[t]    = access & ~apb_req.pwrite & hit_id & (idx == TIDX_W'(t));
      complete[t] = access & apb_req.pwrite & hit_id & (idx == TIDX_W'(t));
    end
  end

  ////////////////////
  // Read mux
  ////////////////////

  assign cfg.rsvd        = '0;
  assign cfg.has_th      = 1'b1;
  assign cfg.prio_levels = 8'(2 ** PRIO_W);
  assign cfg.targets     = 8'(TARGETS);
  assign cfg.sources     = 8'(SOURCES);

  always_comb
  begin
    rdata = '0;
    if (hit_config)
      rdata = cfg;
    else if (hit_prio)
      rdata = prio_rdata.raw;
    else if (hit_en)
      rdata = DATA_W'(ie_rdata[idx]);
    else if (hit_th)
      rdata = DATA_W'(th_rdata[idx]);
    else if (hit_id)
      rdata = id_rdata[idx];
  end

  // Zero wait states
  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pready  = access;
  assign apb_rsp.pslverr = access & err;

endmodule

//--- verilog/plic_enable_regs.sv
`timescale 1ns/10ps

module plic_enable_regs #(
  parameter int SOURCES = 8,
  parameter int TARGETS = 2
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  plic_pkg::reg_wr_t               wr,
  output logic [TARGETS-1:0][SOURCES-1:0] ie
);
  import plic_pkg::*;

  logic                           wr_en;
  // Byte-merged candidate per target
  logic [TARGETS-1:0][DATA_W-1:0] merged;

  assign wr_en = wr.we & wr.sel.enable;

  // Old word zero-extended so unbuilt sources merge in as zero
  always_comb
  begin
    for (int t = 0; t < TARGETS; t++)
    begin
      merged[t] = byte_merge(DATA_W'(ie[t]), wr.wdata, wr.strb);
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  // Only SOURCES bits are kept, upper bits never store
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ie <= '0;
    end
    else
    begin
      for (int t = 0; t < TARGETS; t++)
      begin
        // Selected target only
        if (wr_en && (wr.tidx == TIDX_W'(t)))
          ie[t] <= merged[t][SOURCES-1:0];
      end
    end
  end

endmodule

//--- verilog/plic_pkg.sv
package plic_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // APB data, strobe and address widths
  localparam int DATA_W      = 32;
  localparam int STRB_W      = 4;
  localparam int ADDR_W      = 24;

  // Priority field layout, one nibble per source
  localparam int PRIO_W      = 3;
  localparam int FIELD_W     = 4;

  // Build limits, one word covers every source
  localparam int MAX_SOURCES = 8;
  localparam int MAX_TARGETS = 4;

  // Interrupt ID, 0 means no interrupt
  localparam int ID_W        = 4;
  localparam int TIDX_W      = $clog2(MAX_TARGETS);

  ////////////////////
  // Address map
  ////////////////////

  localparam logic [ADDR_W-1:0] ADDR_CONFIG         = 24'h000000;
  localparam logic [ADDR_W-1:0] ADDR_PRIORITY       = 24'h000004;
  // Enable words at 4 byte pitch per target
  localparam logic [ADDR_W-1:0] ADDR_ENABLE_BASE    = 24'h002000;
  // Threshold at 4 KB pitch per target, claim/complete right above it
  localparam logic [ADDR_W-1:0] ADDR_THRESHOLD_BASE = 24'h200000;
  localparam logic [ADDR_W-1:0] ADDR_ID_OFFSET      = 24'h000004;

  ////////////////////
  // Types
  ////////////////////

  typedef logic [TIDX_W-1:0] tidx_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [STRB_W-1:0] pstrb;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // One-hot datapath select
  typedef struct packed {
    logic prio;
    logic enable;
    logic target;
  } reg_sel_t;

  // Write request from the bus control to the datapaths
  typedef struct packed {
    reg_sel_t          sel;
    tidx_t             tidx;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
  } reg_wr_t;

  // Priority word, seen as a bus word or as per-source nibbles
  typedef union packed {
    logic [DATA_W-1:0]                      raw;
    logic [DATA_W/FIELD_W-1:0][FIELD_W-1:0] field;
  } prio_word_u;

  // Read-only build report
  typedef struct packed {
    logic [6:0] rsvd;
    logic       has_th;
    logic [7:0] prio_levels;
    logic [7:0] targets;
    logic [7:0] sources;
  } config_word_t;

  // Byte lanes with strobe set take new data, others keep the old value
  function automatic logic [DATA_W-1:0] byte_merge(
    input logic [DATA_W-1:0] old_w,
    input logic [DATA_W-1:0] new_w,
    input logic [STRB_W-1:0] strb
  );
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < STRB_W; b++)
    begin
      if (strb[b])
        res[b*8 +: 8] = new_w[b*8 +: 8];
    end
    return res;
  endfunction

endpackage

//--- verilog/plic_priority_regs.sv
`timescale 1ns/10ps

module plic_priority_regs #(
  parameter int SOURCES = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  plic_pkg::reg_wr_t    wr,
  output plic_pkg::prio_word_u prio
);
  import plic_pkg::*;

  // Bits that hold state in the priority word
  prio_word_u        mask;
  logic              wr_en;
  logic [DATA_W-1:0] merged;

  ////////////////////
  // Field mask
  ////////////////////

  // Low PRIO_W bits of each built source, the rest reads zero
  always_comb
  begin
    mask.raw = '0;
    for (int f = 0; f < DATA_W/FIELD_W; f++)
    begin
      if (f < SOURCES)
        mask.field[f] = FIELD_W'((1 << PRIO_W) - 1);
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  assign wr_en  = wr.we & wr.sel.prio;
  // Strobed bytes replace old ones before masking
  assign merged = byte_merge(prio.raw, wr.wdata, wr.strb) & mask.raw;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prio.raw <= '0;
    end
    else if (wr_en)
    begin
      prio.raw <= merged;
    end
  end

endmodule

//--- verilog/plic_regs.sv
`timescale 1ns/10ps

module plic_regs #(
  parameter int SOURCES = 8,
  parameter int TARGETS = 2
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  // APB slave
  input  plic_pkg::apb_req_t                       apb_req,
  output plic_pkg::apb_rsp_t                       apb_rsp,
  // Gateway IDs per target
  input  logic [TARGETS-1:0][plic_pkg::ID_W-1:0]   id,
  // Register outputs to the PLIC core
  output plic_pkg::prio_word_u                     prio,
  output logic [TARGETS-1:0][SOURCES-1:0]          ie,
  output logic [TARGETS-1:0][plic_pkg::PRIO_W-1:0] th,
  // Claim on ID read, complete on ID write
  output logic [TARGETS-1:0]                       claim,
  output logic [TARGETS-1:0]                       complete
);
  import plic_pkg::*;

  // Shared write request
  reg_wr_t                        wr;
  // Target of the current ID access
  tidx_t                          rd_target;
  // Zero-extended ID read words
  logic [TARGETS-1:0][DATA_W-1:0] id_rdata;

  ////////////////////
  // Bus control
  ////////////////////

  plic_apb_ctrl #(
    .SOURCES (SOURCES),
    .TARGETS (TARGETS)
  ) i_plic_apb_ctrl (
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .wr         (wr),
    .rd_target  (rd_target),
    .claim      (claim),
    .complete   (complete),
    .prio_rdata (prio),
    .ie_rdata   (ie),
    .th_rdata   (th),
    .id_rdata   (id_rdata)
  );

  ////////////////////
  // Datapaths
  ////////////////////

  plic_priority_regs #(
    .SOURCES (SOURCES)
  ) i_plic_priority_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .prio  (prio)
  );

  plic_enable_regs #(
    .SOURCES (SOURCES),
    .TARGETS (TARGETS)
  ) i_plic_enable_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .ie    (ie)
  );

  plic_target_regs #(
    .TARGETS (TARGETS)
  ) i_plic_target_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr        (wr),
    .rd_target (rd_target),
    .id        (id),
    .th        (th),
    .id_rdata  (id_rdata)
  );

endmodule

//--- verilog/plic_target_regs.sv
`timescale 1ns/10ps

module plic_target_regs #(
  parameter int TARGETS = 2
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  plic_pkg::reg_wr_t                        wr,
  // Target addressed by the current ID access
  input  plic_pkg::tidx_t                          rd_target,
  input  logic [TARGETS-1:0][plic_pkg::ID_W-1:0]   id,
  output logic [TARGETS-1:0][plic_pkg::PRIO_W-1:0] th,
  output logic [TARGETS-1:0][plic_pkg::DATA_W-1:0] id_rdata
);
  import plic_pkg::*;

  // Threshold lives in byte 0
  logic th_wr_en;

  assign th_wr_en = wr.we & wr.sel.target & wr.strb[0];

  ////////////////////
  // Thresholds
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      th <= '0;
    end
    else
    begin
      for (int t = 0; t < TARGETS; t++)
      begin
        // Upper bits of byte 0 are dropped
        if (th_wr_en && (wr.tidx == TIDX_W'(t)))
          th[t] <= wr.wdata[PRIO_W-1:0];
      end
    end
  end

  ////////////////////
  // ID read words
  ////////////////////

  // Gateway ID zero-extended to a bus word
  // Only the addressed target drives its word, others stay quiet
  always_comb
  begin
    for (int t = 0; t < TARGETS; t++)
    begin
      if (rd_target == TIDX_W'(t))
        id_rdata[t] = DATA_W'(id[t]);
      else
        id_rdata[t] = '0;
    end
  end

endmodule
